// ==== tb.f ====
+incdir+bench
source/rv_pkg.sv
source/instr_fetch.sv
source/instr_decode.sv
source/reg_file.sv
source/alu_execute.sv
source/core_top.sv
bench/tb_clock.sv
bench/tb_core.sv

// ==== Makefile ====
sim:
	verilator --binary --timing --assert -j 0 -f tb.f --top-module tb_core -Mdir obj_dir
	./obj_dir/Vtb_core | tee sim.log
	grep -q "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// ==== bench/tb_program.svh ====
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// R-type word for the OP opcode
function automatic instr_t r_type_word(input logic [6:0] f7, input reg_idx_t rs2,
                                       input reg_idx_t rs1, input logic [2:0] f3,
                                       input reg_idx_t rd);
  return {f7, rs2, rs1, f3, rd, OPC_OP};
endfunction

function automatic instr_t i_type_word(input logic [11:0] imm, input reg_idx_t rs1,
                                       input logic [2:0] f3, input reg_idx_t rd);
  return {imm, rs1, f3, rd, OPC_OP_IMM};
endfunction

function automatic instr_t lui_word(input logic [19:0] imm, input reg_idx_t rd);
  return {imm, rd, OPC_LUI};
endfunction

// One kept instruction over x0..x7 so dependences come often
function automatic instr_t random_instr();
  int unsigned kind;
  reg_idx_t    rd;
  reg_idx_t    rs1;
  reg_idx_t    rs2;
  logic [11:0] imm;
  kind = $urandom % 14;
  rd   = 5'($urandom % 8);
  rs1  = 5'($urandom % 8);
  rs2  = 5'($urandom % 8);
  imm  = 12'($urandom);
  case (kind)
    0:  return r_type_word(7'h00, rs2, rs1, F3_ADD_SUB, rd);
    1:  return r_type_word(7'h20, rs2, rs1, F3_ADD_SUB, rd);  // SUB
    2:  return r_type_word(7'h00, rs2, rs1, F3_SLL, rd);
    3:  return r_type_word(7'h00, rs2, rs1, F3_SRL, rd);
    4:  return r_type_word(7'h00, rs2, rs1, F3_SLT, rd);
    5:  return r_type_word(7'h00, rs2, rs1, F3_XOR, rd);
    6:  return r_type_word(7'h00, rs2, rs1, F3_OR, rd);
    7:  return r_type_word(7'h00, rs2, rs1, F3_AND, rd);
    8:  return i_type_word(imm, rs1, F3_ADD_SUB, rd);
    9:  return i_type_word(imm, rs1, F3_SLT, rd);
    10: return i_type_word(imm, rs1, F3_XOR, rd);
    11: return i_type_word(imm, rs1, F3_OR, rd);
    12: return i_type_word(imm, rs1, F3_AND, rd);
    default: return lui_word(20'($urandom), rd);
  endcase
endfunction

// ISA result of one instruction on the model registers and 1 when it writes
function automatic logic reference_result(input xlen_t regs [NUM_REGS], input instr_t ins,
                                          output reg_idx_t rd, output xlen_t value);
  xlen_t a;
  xlen_t b;
  logic  known;
  a     = regs[ins[19:15]];
  b     = (ins[6:0] == OPC_OP) ? regs[ins[24:20]] : xlen_t'($signed(ins[31:20]));
  rd    = ins[11:7];
  known = ins[6:0] == OPC_OP || ins[6:0] == OPC_OP_IMM;
  case (ins[14:12])
    F3_ADD_SUB: value = (ins[6:0] == OPC_OP && ins[30]) ? a - b : a + b;
    F3_SLL:     value = a << b[5:0];  // RV64 uses 6 shift bits
    F3_SLT:     value = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
    F3_XOR:     value = a ^ b;
    F3_SRL:     value = a >> b[5:0];
    F3_OR:      value = a | b;
    F3_AND:     value = a & b;
    default: begin
      value = '0;  // SLTU, SLTIU
      known = 1'b0;
    end
  endcase
  if (ins[6:0] == OPC_OP_IMM && ins[13:12] == 2'b01) known = 1'b0;  // Immediate shifts
  if (ins[6:0] == OPC_OP && ins[30] && ins[14:12] != F3_ADD_SUB) known = 1'b0;  // SRA
  if (ins[6:0] == OPC_LUI) begin
    known = 1'b1;
    value = xlen_t'($signed({ins[31:12], 12'h000}));  // 32-bit result sign-extended
  end
  return known && rd != '0;
endfunction

// Fills the program and queues the expected write-backs in program order
task automatic build_program();
  xlen_t    model [NUM_REGS];
  reg_idx_t rd;
  xlen_t    value;
  wb_t      item;
  for (int r = 0; r < NUM_REGS; r++) model[r] = '0;
  prog[0] = lui_word(20'($urandom), 5'd1);
  prog[1] = i_type_word(12'($urandom), 5'd1, F3_ADD_SUB, 5'd1);
  for (int k = 2; k < 8; k++) begin
    prog[k] = i_type_word(12'($urandom), 5'(k - 1), F3_ADD_SUB, 5'(k));  // Chain x2..x7
  end
  for (int k = 8; k < PROG_LEN; k++) prog[k] = random_instr();
  n_writes = 0;
  for (int k = 0; k < PROG_LEN; k++) begin
    if (reference_result(model, prog[k], rd, value)) begin
      model[rd] = value;
      item.rd   = rd;
      item.data = value;
      exp_q.push_back(item);
      n_writes++;
    end
  end
endtask

`endif

// ==== bench/tb_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_core import rv_pkg::*; ();

  localparam int          PROG_LEN   = 200;
  localparam addr_t       ENTRY      = 64'h1000;
  localparam int          MAX_CYCLES = PROG_LEN * 12 + 200;
  localparam instr_t      FILLER     = 32'h0000_0013;  // ADDI x0, x0, 0
  localparam int unsigned SEED       = 32'haf2ab7d2;

  logic   clk;
  logic   reset;
  addr_t  entry;
  logic   instr_valid;
  instr_t instr_data;
  logic   instr_req;
  addr_t  instr_addr;
  logic   wb_valid;
  wb_t    wb;

  instr_t prog [PROG_LEN];
  wb_t    exp_q [$];  // Expected write-backs, oldest first
  wb_t    expected;
  addr_t  next_addr = ENTRY;
  int     n_writes  = 0;
  int     wb_count  = 0;
  int     fetches   = 0;
  int     errors    = 0;
  int     cycles    = 0;

  `include "tb_program.svh"

  tb_clock i_tb_clock (.clk, .reset);

  core_top i_core_top (
    .clk, .reset, .entry, .instr_valid, .instr_data,
    .instr_req, .instr_addr, .wb_valid, .wb
  );

  // Instruction memory, answers each request after 1 to 4 cycles
  initial begin
    int unsigned delay;
    int          idx;
    instr_valid = 1'b0;
    instr_data  = '0;
    forever begin
      @(posedge clk);
      #1;
      if (!reset && instr_req) begin
        if (instr_addr !== next_addr) begin
          errors++;
          $display("[ERROR] instr_addr got %h expected %h", instr_addr, next_addr);
        end
        next_addr = next_addr + INSTR_BYTES;
        fetches++;
        idx   = int'((instr_addr - ENTRY) >> 2);
        delay = 1 + $urandom % 4;
        repeat (delay) begin
          @(posedge clk);
          #1;
          if (instr_req) begin
            errors++;
            $display("New fetch request while the previous one is unanswered");
          end
        end
        instr_valid = 1'b1;
        instr_data  = (idx >= 0 && idx < PROG_LEN) ? prog[idx] : FILLER;  // Fillers past the end
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
      end
    end
  end

  // Write-back checker, sampled mid-cycle
  always @(negedge clk) begin
    if (!reset && wb_valid) begin
      wb_count++;
      if (exp_q.size() == 0) begin
        errors++;
        $display("Write-back to x%0d with no writing instruction left", wb.rd);
      end else begin
        expected = exp_q.pop_front();
        if (wb.rd !== expected.rd) begin
          errors++;
          $display("[ERROR] wb.rd got %h expected %h", wb.rd, expected.rd);
        end
        if (wb.data !== expected.data) begin
          errors++;
          $display("[ERROR] wb.data got %h expected %h", wb.data, expected.data);
        end
      end
    end
  end

  // Run limit
  initial begin
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles with %0d of %0d write-backs seen",
             cycles, wb_count, n_writes);
    $display("Finished with errors");
    $finish;
  end

  initial begin
    entry = ENTRY;
    void'($urandom(SEED));
    build_program();
    while (wb_count < n_writes) @(posedge clk);
    repeat (20) @(posedge clk);  // Trailing fillers must stay silent
    if (exp_q.size() != 0 || wb_count != n_writes) begin
      errors++;
      $display("Write-back count %0d does not match %0d writing instructions",
               wb_count, n_writes);
    end
    $display("Write-backs %0d of %0d, fetches %0d, errors %0d",
             wb_count, n_writes, fetches, errors);
    if (errors == 0) $display("Finished with no errors");
    else $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/tb_clock.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // 10 ns period
  end

  // Held for 16 rising edges, dropped just after the last one
  initial begin
    reset = 1'b1;
    repeat (16) @(posedge clk);
    #1;
    reset = 1'b0;
  end

endmodule

`default_nettype wire

// ==== source/core_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module core_top import rv_pkg::*; (
  input  wire logic   clk,
  input  wire logic   reset,
  input  wire addr_t  entry,
  input  wire logic   instr_valid,
  input  wire instr_t instr_data,
  output logic        instr_req,
  output addr_t       instr_addr,
  output logic        wb_valid,     // Also the trace strobe
  output wb_t         wb
);

  logic     if_valid;
  instr_t   if_instr;
  logic     id_take;
  reg_idx_t rd_idx_a;
  reg_idx_t rd_idx_b;
  xlen_t    rd_data_a;
  xlen_t    rd_data_b;
  decoded_t ex_in;
  logic     ex_in_valid;

  instr_fetch i_instr_fetch (
    .clk, .reset, .entry, .instr_valid, .instr_data, .id_take,
    .instr_req, .instr_addr, .if_valid, .if_instr
  );

  instr_decode i_instr_decode (
    .clk, .reset, .if_valid, .if_instr, .rd_data_a, .rd_data_b,
    .wb_valid, .wb, .id_take, .rd_idx_a, .rd_idx_b, .ex_in, .ex_in_valid
  );

  reg_file i_reg_file (
    .clk, .reset, .rd_idx_a, .rd_idx_b, .wb_valid, .wb,
    .rd_data_a, .rd_data_b
  );

  alu_execute i_alu_execute (
    .clk, .reset, .ex_in, .ex_in_valid, .wb_valid, .wb
  );

endmodule

`default_nettype wire

// ==== source/alu_execute.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu_execute import rv_pkg::*; (
  input  wire logic     clk,
  input  wire logic     reset,
  input  wire decoded_t ex_in,
  input  wire logic     ex_in_valid,
  output logic          wb_valid,
  output wb_t           wb
);

  xlen_t      op_a;
  xlen_t      op_b;
  logic [5:0] shamt;   // RV64 shift amount
  xlen_t      result;

  assign op_a  = ex_in.operand_a;
  assign op_b  = ex_in.operand_b;
  assign shamt = op_b[5:0];

  always_comb begin
    case (ex_in.alu_op)
      ALU_ADD: result = op_a + op_b;
      ALU_SUB: result = op_a - op_b;
      ALU_AND: result = op_a & op_b;
      ALU_OR:  result = op_a | op_b;
      ALU_XOR: result = op_a ^ op_b;
      ALU_SLL: result = op_a << shamt;
      ALU_SRL: result = op_a >> shamt;  // Logical, zero fill
      ALU_SLT: result = {63'd0, $signed(op_a) < $signed(op_b)};
      default: result = op_b;           // Pass B for LUI
    endcase
  end

  // Only real register writes raise the strobe
  always_ff @(posedge clk) begin
    if (reset) begin
      wb_valid <= 1'b0;
    end else begin
      wb_valid <= ex_in_valid && ex_in.wr_en;
    end
  end

  always_ff @(posedge clk) begin
    if (ex_in_valid) begin
      wb.rd   <= ex_in.rd;
      wb.data <= result;
    end
  end

endmodule

`default_nettype wire

// ==== source/reg_file.sv ====
`timescale 1ns/10ps
`default_nettype none

module reg_file import rv_pkg::*; (
  input  wire logic     clk,
  input  wire logic     reset,
  input  wire reg_idx_t rd_idx_a,
  input  wire reg_idx_t rd_idx_b,
  input  wire logic     wb_valid,
  input  wire wb_t      wb,
  output xlen_t         rd_data_a,
  output xlen_t         rd_data_b
);

  xlen_t regs [NUM_REGS];

  // Combinational read ports, x0 is never written so it stays zero
  assign rd_data_a = regs[rd_idx_a];
  assign rd_data_b = regs[rd_idx_b];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_valid && wb.rd != '0) begin
      regs[wb.rd] <= wb.data;  // Write at end of the wb_valid cycle
    end
  end

  // Execute filters x0 writes before they reach the port
  a_no_x0_write: assert property (
    @(posedge clk) disable iff (reset) wb_valid |-> wb.rd != '0
  );

endmodule

`default_nettype wire

// ==== source/instr_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module instr_decode import rv_pkg::*; (
  input  wire logic     clk,
  input  wire logic     reset,
  input  wire logic     if_valid,
  input  wire instr_t   if_instr,
  input  wire xlen_t    rd_data_a,
  input  wire xlen_t    rd_data_b,
  input  wire logic     wb_valid,
  input  wire wb_t      wb,
  output logic          id_take,
  output reg_idx_t      rd_idx_a,
  output reg_idx_t      rd_idx_b,
  output decoded_t      ex_in,
  output logic          ex_in_valid
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       alt;      // funct7 bit 5, selects SUB
  reg_idx_t   rs1;
  reg_idx_t   rs2;
  reg_idx_t   rd;
  xlen_t      imm_i;
  xlen_t      imm_u;
  logic       use_rs1;
  logic       use_rs2;
  logic       known;    // Supported instruction
  alu_op_e    alu_op;
  logic       busy_a;
  logic       busy_b;
  decoded_t   dec;

  assign opcode = if_instr[6:0];
  assign rd     = if_instr[11:7];
  assign funct3 = if_instr[14:12];
  assign rs1    = if_instr[19:15];
  assign rs2    = if_instr[24:20];
  assign alt    = if_instr[30];

  assign rd_idx_a = rs1;
  assign rd_idx_b = rs2;

  assign imm_i = {{52{if_instr[31]}}, if_instr[31:20]};
  assign imm_u = {{32{if_instr[31]}}, if_instr[31:12], 12'h000};

  always_comb begin
    alu_op  = ALU_ADD;
    known   = 1'b0;
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    case (opcode)
      OPC_OP: begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        known   = !alt || funct3 == F3_ADD_SUB;  // SRA not kept
        case (funct3)
          F3_ADD_SUB: alu_op = alt ? ALU_SUB : ALU_ADD;
          F3_SLL:     alu_op = ALU_SLL;
          F3_SLT:     alu_op = ALU_SLT;
          F3_XOR:     alu_op = ALU_XOR;
          F3_SRL:     alu_op = ALU_SRL;
          F3_OR:      alu_op = ALU_OR;
          F3_AND:     alu_op = ALU_AND;
          default:    known  = 1'b0;  // SLTU
        endcase
      end
      OPC_OP_IMM: begin
        use_rs1 = 1'b1;
        known   = 1'b1;
        case (funct3)
          F3_ADD_SUB: alu_op = ALU_ADD;
          F3_SLT:     alu_op = ALU_SLT;
          F3_XOR:     alu_op = ALU_XOR;
          F3_OR:      alu_op = ALU_OR;
          F3_AND:     alu_op = ALU_AND;
          default:    known  = 1'b0;  // Immediate shifts, SLTIU
        endcase
      end
      OPC_LUI: begin
        alu_op = ALU_PASS_B;  // Result is the U-immediate
        known  = 1'b1;
      end
      default: ;  // Passes down with no write
    endcase
  end

  // Source still waiting on an older write, in decode/execute or on wb
  assign busy_a = use_rs1 && rs1 != '0 &&
                  ((ex_in_valid && ex_in.wr_en && ex_in.rd == rs1) ||
                   (wb_valid && wb.rd == rs1));
  assign busy_b = use_rs2 && rs2 != '0 &&
                  ((ex_in_valid && ex_in.wr_en && ex_in.rd == rs2) ||
                   (wb_valid && wb.rd == rs2));

  assign id_take = if_valid && !busy_a && !busy_b;

  always_comb begin
    dec.alu_op    = alu_op;
    dec.rd        = rd;
    dec.wr_en     = known && rd != '0;
    dec.operand_a = rd_data_a;
    if (opcode == OPC_OP) dec.operand_b = rd_data_b;
    else if (opcode == OPC_LUI) dec.operand_b = imm_u;
    else dec.operand_b = imm_i;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ex_in_valid <= 1'b0;
    end else begin
      ex_in_valid <= id_take;
    end
  end

  always_ff @(posedge clk) begin
    if (id_take) begin
      ex_in <= dec;
    end
  end

  // A refetch with at least one cycle of memory latency separates two takes
  a_take_spacing: assert property (
    @(posedge clk) disable iff (reset) ex_in_valid |=> !ex_in_valid
  );

endmodule

`default_nettype wire

// ==== source/instr_fetch.sv ====
`timescale 1ns/10ps
`default_nettype none

module instr_fetch import rv_pkg::*; (
  input  wire logic   clk,
  input  wire logic   reset,
  input  wire addr_t  entry,        // Program entry point
  input  wire logic   instr_valid,  // Reply strobe from memory
  input  wire instr_t instr_data,
  input  wire logic   id_take,      // Decode consumes the slot
  output logic        instr_req,
  output addr_t       instr_addr,
  output logic        if_valid,
  output instr_t      if_instr
);

  fetch_state_e state;
  addr_t        pc;

  assign instr_req  = (state == FETCH_REQ);  // One cycle per request
  assign instr_addr = pc;

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= FETCH_HOLD;  // Empty slot, first request follows
      pc       <= entry;
      if_valid <= 1'b0;
    end else begin
      case (state)
        FETCH_REQ: state <= FETCH_WAIT;
        FETCH_WAIT: begin
          if (instr_valid) begin
            if_valid <= 1'b1;        // Word now in the slot
            state    <= FETCH_HOLD;
          end
        end
        FETCH_HOLD: begin
          if (id_take) begin
            if_valid <= 1'b0;
            pc       <= pc + INSTR_BYTES;  // Next sequential word
            state    <= FETCH_REQ;
          end else if (!if_valid) begin
            state <= FETCH_REQ;            // Nothing held, go fetch
          end
        end
        default: state <= FETCH_HOLD;
      endcase
    end
  end

  // Capture the returned word
  always_ff @(posedge clk) begin
    if (state == FETCH_WAIT && instr_valid) begin
      if_instr <= instr_data;
    end
  end

  // Memory only replies to the single outstanding request
  a_reply_in_wait: assert property (
    @(posedge clk) disable iff (reset) instr_valid |-> state == FETCH_WAIT
  );

endmodule

`default_nettype wire

// ==== source/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

  // Data widths
  typedef logic [63:0] xlen_t;     // Register or data word
  typedef logic [31:0] instr_t;    // Instruction word
  typedef logic [4:0]  reg_idx_t;  // Register index
  typedef logic [63:0] addr_t;     // Instruction address

  // Kept major opcodes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;

  // funct3 codes shared by OP and OP-IMM
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL     = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  localparam addr_t INSTR_BYTES = 64'd4;  // PC step
  localparam int    NUM_REGS    = 32;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLL, ALU_SRL, ALU_SLT, ALU_PASS_B
  } alu_op_e;

  typedef enum logic [1:0] {
    FETCH_REQ,   // Request on the port
    FETCH_WAIT,  // Waiting for the reply
    FETCH_HOLD   // Word held for decode
  } fetch_state_e;

  // Decode/execute register contents
  typedef struct packed {
    alu_op_e  alu_op;
    reg_idx_t rd;
    logic     wr_en;      // Writes a register other than x0
    xlen_t    operand_a;
    xlen_t    operand_b;
  } decoded_t;

  // Write-back and trace port
  typedef struct packed {
    reg_idx_t rd;
    xlen_t    data;
  } wb_t;

endpackage

`default_nettype wire
